// ==== vlog.f ====
rtl/radar_capture_pkg.sv
rtl/chirp_source_mux.sv
rtl/capture_sequencer.sv
rtl/capture_word_builder.sv
rtl/radar_capture_top.sv
tb/radar_capture_asserts.sv
tb/tb_radar_capture.sv

// ==== run.sh ====
#!/bin/sh
# build and run the capture testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_radar_capture -f vlog.f -o tb_radar_capture_sim

# keep running past the first assertion so the testbench reports it
out=$(./obj_dir/tb_radar_capture_sim +verilator+error+limit+100 2>&1 || true)
echo "$out"

echo "$out" | grep -q "TEST RESULT: PASS"

// ==== tb/tb_radar_capture.sv ====
`timescale 1ns/1ps

module tb_radar_capture
  import radar_capture_pkg::*;
();

  logic              clk_245_76MHz;
  logic              cpu_reset;
  logic              chirp_init_i;
  logic              chirp_enable_i;
  logic              adc_enable_i;
  logic [CTRL_W-1:0] chirp_control_word_i;
  logic [IQ_W-1:0]   adc_iq_i;
  logic [IQ_W-1:0]   dac_iq_i;
  logic              sample_valid_i;
  logic              dds_ready_i;
  logic              dds_done_i;
  logic              dds_active_i;
  logic              wfrm_ready_i;
  logic              wfrm_done_i;
  logic              wfrm_active_i;
  logic              dds_init_o;
  logic              dds_enable_o;
  logic              wfrm_init_o;
  logic              wfrm_enable_o;
  logic              chirp_ready_o;
  logic              chirp_done_o;
  logic              chirp_active_o;
  capture_word_t     capture_word_o;
  logic              capture_valid_o;
  logic              capture_first_o;
  logic              capture_last_o;

  logic [31:0] lcg_state;
  logic [3:0]  route_step;
  logic [1:0]  src_field;

  radar_capture_top radar_capture_top_inst (.*);

  // 100 ns period
  initial clk_245_76MHz = 1'b0;
  always #50 clk_245_76MHz = ~clk_245_76MHz;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic stop_failed(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation aborted");
  endtask

  // one clock, new inputs 1 ns after the edge
  task automatic next_cycle();
    @(posedge clk_245_76MHz);
    #1;
    lcg_state = lcg_next(lcg_state);
    adc_iq_i  = lcg_state;
    lcg_state = lcg_next(lcg_state);
    dac_iq_i  = lcg_state;
    // upper lcg bits for the generator status lines
    {dds_ready_i, dds_done_i, dds_active_i} = lcg_state[29:27];
    {wfrm_ready_i, wfrm_done_i, wfrm_active_i} = lcg_state[26:24];
    // walk all 16 route pairs
    route_step = route_step + 4'd1;
    chirp_control_word_i[ROUTE_L_LSB +: 2] = route_step[1:0];
    chirp_control_word_i[ROUTE_U_LSB +: 2] = route_step[3:2];
    chirp_control_word_i[SRC_LSB +: 2]     = src_field;
  endtask

  // bounded wait on first or last strobe
  task automatic wait_strobe(input logic last_sel, input int limit, input string what);
    int n;
    n = 0;
    while (!(last_sel ? capture_last_o : capture_first_o)) begin
      if (n == limit) begin
        stop_failed({"timeout waiting for ", what});
      end
      next_cycle();
      n = n + 1;
    end
  endtask

  ////////////////////////////////////////
  // one chirp with one capture frame
  ////////////////////////////////////////

  task automatic run_frame(input logic [1:0] src);
    int hold;
    hold = 0;
    // two cycles so the source is latched before init
    src_field = src;
    next_cycle();
    next_cycle();
    chirp_init_i = 1'b1;
    next_cycle();
    chirp_init_i   = 1'b0;
    chirp_enable_i = 1'b1;
    adc_enable_i   = 1'b1;
    wait_strobe(1'b0, 64, "capture_first_o after the chirp start");
    lcg_state = lcg_next(lcg_state);
    hold = 20 + int'(lcg_state[30:24]);
    for (int i = 0; i < hold; i++) begin
      next_cycle();
      // source flip mid chirp, must stay hidden until enable drops
      if (i == hold / 2) begin
        src_field = ~src;
      end
    end
    adc_enable_i = 1'b0;
    wait_strobe(1'b1, 200, "capture_last_o after the capture stop");
    next_cycle();
    chirp_enable_i = 1'b0;
    next_cycle();
  endtask

  // first assertion error ends the run
  always @(negedge clk_245_76MHz) begin
    if (radar_capture_top_inst.radar_capture_asserts_inst.err_cnt != 0) begin
      stop_failed("an assertion check failed, see the error above");
    end
  end

  initial begin
    lcg_state            = 32'd69307;
    route_step           = 4'd0;
    src_field            = 2'b00;
    cpu_reset            = 1'b1;
    chirp_init_i         = 1'b0;
    chirp_enable_i       = 1'b0;
    adc_enable_i         = 1'b0;
    chirp_control_word_i = '0;
    adc_iq_i             = '0;
    dac_iq_i             = '0;
    sample_valid_i       = 1'b1;
    dds_ready_i          = 1'b0;
    dds_done_i           = 1'b0;
    dds_active_i         = 1'b0;
    wfrm_ready_i         = 1'b0;
    wfrm_done_i          = 1'b0;
    wfrm_active_i        = 1'b0;
    repeat (16) @(posedge clk_245_76MHz);
    #1;
    cpu_reset = 1'b0;
    repeat (4) next_cycle();
    // chirp dds, waveform, the other chirp code, waveform again
    run_frame(2'b00);
    run_frame(2'b11);
    run_frame(2'b01);
    run_frame(2'b11);
    repeat (8) next_cycle();
    if (radar_capture_top_inst.radar_capture_asserts_inst.err_cnt == 0) begin
      $display("TEST RESULT: PASS");
      $finish;
    end else begin
      stop_failed("assertion failures were counted during the run");
    end
  end

endmodule

// ==== tb/radar_capture_asserts.sv ====
`timescale 1ns/1ps

module radar_capture_asserts
  import radar_capture_pkg::*;
(
  input logic              clk_245_76MHz,
  input logic              cpu_reset,
  input logic              chirp_init_i,
  input logic              chirp_enable_i,
  input logic [CTRL_W-1:0] chirp_control_word_i,
  input logic [IQ_W-1:0]   adc_iq_i,
  input logic [IQ_W-1:0]   dac_iq_i,
  input logic              dds_ready_i,
  input logic              dds_done_i,
  input logic              dds_active_i,
  input logic              wfrm_ready_i,
  input logic              wfrm_done_i,
  input logic              wfrm_active_i,
  input logic              dds_init_o,
  input logic              dds_enable_o,
  input logic              wfrm_init_o,
  input logic              wfrm_enable_o,
  input logic              chirp_ready_o,
  input logic              chirp_done_o,
  input logic              chirp_active_o,
  input capture_word_t     capture_word_o,
  input logic              capture_valid_o,
  input logic              capture_first_o,
  input logic              capture_last_o
);

  int unsigned          err_cnt = 0;
  logic [CNT_W-1:0]     cycle_cnt;
  logic [CNT_W-1:0]     valid_cnt;
  logic [CNT_W-1:0]     frame_len;
  logic                 in_frame;
  logic [1:0]           src_q;
  logic [1:0]           route_l_q;
  logic [1:0]           route_u_q;
  logic                 wfrm_pick;
  logic [3:0]           exp_strobes;
  logic [2:0]           exp_status;
  logic [3:0][IQ_W-1:0] half_src;
  logic                 hdr_word;
  logic                 data_word;

  ////////////////////////////////////////
  // reference state
  ////////////////////////////////////////

  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      cycle_cnt <= '0;
      valid_cnt <= '0;
      frame_len <= '0;
      in_frame  <= 1'b0;
      src_q     <= 2'b00;
      route_l_q <= ROUTE_ADC;
      route_u_q <= ROUTE_ADC;
    end else begin
      cycle_cnt <= cycle_cnt + CNT_W'(1);
      // route codes one cycle late
      route_l_q <= chirp_control_word_i[ROUTE_L_LSB +: 2];
      route_u_q <= chirp_control_word_i[ROUTE_U_LSB +: 2];
      // source only moves between chirps
      if (!chirp_enable_i) begin
        src_q <= chirp_control_word_i[SRC_LSB +: 2];
      end
      if (capture_valid_o) begin
        valid_cnt <= valid_cnt + CNT_W'(1);
        // header word opens the count at one
        frame_len <= capture_first_o ? CNT_W'(1) : frame_len + CNT_W'(1);
      end
      if (capture_first_o) begin
        in_frame <= 1'b1;
      end else if (capture_last_o) begin
        in_frame <= 1'b0;
      end
    end
  end

  // waveform generator on source code 3 only
  assign wfrm_pick   = (src_q == 2'b11);
  // order is dds_init, dds_enable, wfrm_init, wfrm_enable
  assign exp_strobes = wfrm_pick ? {2'b00, chirp_init_i, chirp_enable_i}
                                 : {chirp_init_i, chirp_enable_i, 2'b00};
  assign exp_status  = wfrm_pick ? {wfrm_ready_i, wfrm_done_i, wfrm_active_i}
                                 : {dds_ready_i, dds_done_i, dds_active_i};
  assign hdr_word    = capture_first_o | capture_last_o;
  assign data_word   = capture_valid_o & ~hdr_word;

  // half-word table indexed by route code
  always_comb begin
    half_src[ROUTE_ADC]     = adc_iq_i;
    half_src[ROUTE_DAC]     = dac_iq_i;
    half_src[ROUTE_SAMPLES] = valid_cnt;
    half_src[ROUTE_GLOBAL]  = cycle_cnt;
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  reset_quiet: assert property (@(posedge clk_245_76MHz)
    $fell(cpu_reset) |-> ({capture_valid_o, capture_first_o, capture_last_o, dds_init_o,
                           dds_enable_o, wfrm_init_o, wfrm_enable_o} == 7'd0))
    else begin
      err_cnt = err_cnt + 1;
      $error("control outputs are not all low after reset");
    end

  strobe_steer: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    {dds_init_o, dds_enable_o, wfrm_init_o, wfrm_enable_o} == exp_strobes)
    else begin
      err_cnt = err_cnt + 1;
      $error("Mismatch {dds_init_o,dds_enable_o,wfrm_init_o,wfrm_enable_o}: got %h expected %h",
             $sampled({dds_init_o, dds_enable_o, wfrm_init_o, wfrm_enable_o}),
             $sampled(exp_strobes));
    end

  status_mux: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    {chirp_ready_o, chirp_done_o, chirp_active_o} == exp_status)
    else begin
      err_cnt = err_cnt + 1;
      $error("Mismatch {chirp_ready_o,chirp_done_o,chirp_active_o}: got %h expected %h",
             $sampled({chirp_ready_o, chirp_done_o, chirp_active_o}), $sampled(exp_status));
    end

  // header and trailer carry both counts
  hdr_global: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    hdr_word |-> capture_word_o.hdr.glbl == cycle_cnt)
    else begin
      err_cnt = err_cnt + 1;
      $error("Mismatch capture_word_o.hdr.glbl: got %h expected %h",
             $sampled(capture_word_o.hdr.glbl), $sampled(cycle_cnt));
    end

  hdr_samples: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    hdr_word |-> capture_word_o.hdr.samples == valid_cnt)
    else begin
      err_cnt = err_cnt + 1;
      $error("Mismatch capture_word_o.hdr.samples: got %h expected %h",
             $sampled(capture_word_o.hdr.samples), $sampled(valid_cnt));
    end

  data_upper: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    data_word |-> capture_word_o.data.upper == half_src[route_u_q])
    else begin
      err_cnt = err_cnt + 1;
      $error("Mismatch capture_word_o.data.upper: got %h expected %h",
             $sampled(capture_word_o.data.upper), $sampled(half_src[route_u_q]));
    end

  data_lower: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    data_word |-> capture_word_o.data.lower == half_src[route_l_q])
    else begin
      err_cnt = err_cnt + 1;
      $error("Mismatch capture_word_o.data.lower: got %h expected %h",
             $sampled(capture_word_o.data.lower), $sampled(half_src[route_l_q]));
    end

  // trailer counted too, so frame_len plus one
  frame_blocks: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    capture_last_o |-> capture_valid_o && ((frame_len + CNT_W'(1)) % ALIGN_WORDS == 0))
    else begin
      err_cnt = err_cnt + 1;
      $error("frame of %0d words does not end on a block boundary",
             $sampled(frame_len) + 1);
    end

  first_opens: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    capture_first_o |-> !in_frame)
    else begin
      err_cnt = err_cnt + 1;
      $error("capture_first_o arrived while a frame was still open");
    end

  last_closes: assert property (@(posedge clk_245_76MHz) disable iff (cpu_reset)
    capture_last_o |-> in_frame)
    else begin
      err_cnt = err_cnt + 1;
      $error("capture_last_o arrived without a preceding capture_first_o");
    end

endmodule

bind radar_capture_top radar_capture_asserts radar_capture_asserts_inst (.*);

// ==== rtl/radar_capture_top.sv ====
`timescale 1ns/1ps

module radar_capture_top
  import radar_capture_pkg::*;
(
  input  logic              clk_245_76MHz,
  input  logic              cpu_reset,
  input  logic              chirp_init_i,
  input  logic              chirp_enable_i,
  input  logic              adc_enable_i,
  input  logic [CTRL_W-1:0] chirp_control_word_i,
  input  logic [IQ_W-1:0]   adc_iq_i,
  input  logic [IQ_W-1:0]   dac_iq_i,
  input  logic              sample_valid_i,
  input  logic              dds_ready_i,
  input  logic              dds_done_i,
  input  logic              dds_active_i,
  input  logic              wfrm_ready_i,
  input  logic              wfrm_done_i,
  input  logic              wfrm_active_i,
  output logic              dds_init_o,
  output logic              dds_enable_o,
  output logic              wfrm_init_o,
  output logic              wfrm_enable_o,
  output logic              chirp_ready_o,
  output logic              chirp_done_o,
  output logic              chirp_active_o,
  output capture_word_t     capture_word_o,
  output logic              capture_valid_o,
  output logic              capture_first_o,
  output logic              capture_last_o
);

  logic wfrm_selected;

  ////////////////////////////////////////
  // generator select and status
  ////////////////////////////////////////

  chirp_source_mux chirp_source_mux_inst (
    .clk_245_76MHz   (clk_245_76MHz),
    .cpu_reset       (cpu_reset),
    .chirp_init_i    (chirp_init_i),
    .chirp_enable_i  (chirp_enable_i),
    .source_field_i  (chirp_control_word_i[SRC_LSB +: 2]),
    .dds_ready_i     (dds_ready_i),
    .dds_done_i      (dds_done_i),
    .dds_active_i    (dds_active_i),
    .wfrm_ready_i    (wfrm_ready_i),
    .wfrm_done_i     (wfrm_done_i),
    .wfrm_active_i   (wfrm_active_i),
    .wfrm_selected_o (wfrm_selected),
    .dds_init_o      (dds_init_o),
    .dds_enable_o    (dds_enable_o),
    .wfrm_init_o     (wfrm_init_o),
    .wfrm_enable_o   (wfrm_enable_o),
    .chirp_ready_o   (chirp_ready_o),
    .chirp_done_o    (chirp_done_o),
    .chirp_active_o  (chirp_active_o)
  );

  // frame strobes go straight out as the capture stream
  capture_sequencer capture_sequencer_inst (
    .clk_245_76MHz   (clk_245_76MHz),
    .cpu_reset       (cpu_reset),
    .chirp_init_i    (chirp_init_i),
    .adc_enable_i    (adc_enable_i),
    .sample_valid_i  (sample_valid_i),
    .wfrm_selected_i (wfrm_selected),
    .word_we_o       (capture_valid_o),
    .frame_first_o   (capture_first_o),
    .frame_last_o    (capture_last_o)
  );

  capture_word_builder capture_word_builder_inst (
    .clk_245_76MHz  (clk_245_76MHz),
    .cpu_reset      (cpu_reset),
    .route_l_i      (chirp_control_word_i[ROUTE_L_LSB +: 2]),
    .route_u_i      (chirp_control_word_i[ROUTE_U_LSB +: 2]),
    .adc_iq_i       (adc_iq_i),
    .dac_iq_i       (dac_iq_i),
    .word_we_i      (capture_valid_o),
    .frame_first_i  (capture_first_o),
    .frame_last_i   (capture_last_o),
    .capture_word_o (capture_word_o)
  );

endmodule

// ==== rtl/capture_word_builder.sv ====
`timescale 1ns/1ps

module capture_word_builder
  import radar_capture_pkg::*;
(
  input  logic            clk_245_76MHz,
  input  logic            cpu_reset,
  input  logic [1:0]      route_l_i,
  input  logic [1:0]      route_u_i,
  input  logic [IQ_W-1:0] adc_iq_i,
  input  logic [IQ_W-1:0] dac_iq_i,
  input  logic            word_we_i,
  input  logic            frame_first_i,
  input  logic            frame_last_i,
  output capture_word_t   capture_word_o
);

  logic [1:0]       route_l_r;
  logic [1:0]       route_u_r;
  logic [CNT_W-1:0] glbl_cnt;
  logic [CNT_W-1:0] sample_cnt;

  // pick one half-word source by route code
  function automatic logic [WORD_W/2-1:0] route_sel(
    input logic [1:0]      code,
    input logic [IQ_W-1:0] adc,
    input logic [IQ_W-1:0] dac,
    input logic [CNT_W-1:0] smp,
    input logic [CNT_W-1:0] glb
  );
    logic [WORD_W/2-1:0] sel;
    case (code)
      ROUTE_ADC:     sel = adc;
      ROUTE_DAC:     sel = dac;
      ROUTE_SAMPLES: sel = smp;
      default:       sel = glb;
    endcase
    return sel;
  endfunction

  // routes sampled every cycle, one cycle behind the control word
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      route_l_r <= ROUTE_ADC;
      route_u_r <= ROUTE_ADC;
    end else begin
      route_l_r <= route_l_i;
      route_u_r <= route_u_i;
    end
  end

  ////////////////////////////////////////
  // counters
  ////////////////////////////////////////

  // free running timestamp
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      glbl_cnt <= '0;
    end else begin
      glbl_cnt <= glbl_cnt + 1'b1;
    end
  end

  // words handed out since reset
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      sample_cnt <= '0;
    end else if (word_we_i) begin
      sample_cnt <= sample_cnt + 1'b1;
    end
  end

  // header and trailer carry both counters, else routed halves
  always_comb begin
    if (frame_first_i || frame_last_i) begin
      capture_word_o.hdr.glbl    = glbl_cnt;
      capture_word_o.hdr.samples = sample_cnt;
    end else begin
      capture_word_o.data.upper = route_sel(route_u_r, adc_iq_i, dac_iq_i, sample_cnt, glbl_cnt);
      capture_word_o.data.lower = route_sel(route_l_r, adc_iq_i, dac_iq_i, sample_cnt, glbl_cnt);
    end
  end

endmodule

// ==== rtl/capture_sequencer.sv ====
`timescale 1ns/1ps

module capture_sequencer
  import radar_capture_pkg::*;
(
  input  logic clk_245_76MHz,
  input  logic cpu_reset,
  input  logic chirp_init_i,
  input  logic adc_enable_i,
  input  logic sample_valid_i,
  input  logic wfrm_selected_i,
  output logic word_we_o,
  output logic frame_first_o,
  output logic frame_last_o
);

  logic               en_r;
  logic               capture_on;
  logic               frame_first_r;
  logic [LAT_W-1:0]   lat_cnt;
  logic [ALIGN_W-1:0] word_cnt;
  logic [ALIGN_W-1:0] align_cnt;

  logic lat_zero;
  logic align_pend;
  logic en_fall;
  logic start_cond;
  logic pre_last;

  ////////////////////////////////////////
  // frame conditions
  ////////////////////////////////////////

  assign lat_zero   = (lat_cnt == '0);
  assign align_pend = (align_cnt != '0);
  assign en_fall    = en_r & ~adc_enable_i;

  // start latency over, capture not yet running
  assign start_cond = lat_zero & en_r & ~capture_on;

  // one cycle before the stop latency runs out
  assign pre_last = (lat_cnt == LAT_W'(1)) & capture_on & ~en_r;

  // enable registered once
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      en_r <= 1'b0;
    end else begin
      en_r <= adc_enable_i;
    end
  end

  // latency countdown, reloaded on init and on enable drop
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      lat_cnt <= '0;
    end else if (chirp_init_i) begin
      lat_cnt <= wfrm_selected_i ? LAT_W'(WFRM_DELAY) : LAT_W'(CHIRP_DELAY);
    end else if (en_fall) begin
      lat_cnt <= wfrm_selected_i ? LAT_W'(WFRM_DELAY_END) : LAT_W'(CHIRP_DELAY);
    end else if (!lat_zero) begin
      lat_cnt <= lat_cnt - 1'b1;
    end
  end

  // capture level follows en_r only once latency and padding are done
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      capture_on <= 1'b0;
    end else if (lat_zero && !align_pend) begin
      capture_on <= en_r;
    end
  end

  // header strobe lands with the first captured word
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      frame_first_r <= 1'b0;
    end else begin
      frame_first_r <= start_cond;
    end
  end

  ////////////////////////////////////////
  // block alignment
  ////////////////////////////////////////

  // words written this frame, modulo block size
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      word_cnt <= '0;
    end else if (start_cond) begin
      word_cnt <= '0;
    end else if (word_we_o) begin
      word_cnt <= word_cnt + 1'b1;
    end
  end

  // padding words still owed to the block
  // block size minus words so far, the pre-last word and the trailer
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      align_cnt <= '0;
    end else if (pre_last) begin
      align_cnt <= ALIGN_W'(ALIGN_WORDS - 2) - word_cnt;
    end else if (align_pend) begin
      align_cnt <= align_cnt - 1'b1;
    end
  end

  assign word_we_o     = capture_on & sample_valid_i;
  assign frame_first_o = frame_first_r;
  // trailer on the last padded cycle
  assign frame_last_o  = lat_zero & capture_on & ~en_r & ~align_pend;

endmodule

// ==== rtl/chirp_source_mux.sv ====
`timescale 1ns/1ps

module chirp_source_mux
  import radar_capture_pkg::*;
(
  input  logic       clk_245_76MHz,
  input  logic       cpu_reset,
  input  logic       chirp_init_i,
  input  logic       chirp_enable_i,
  input  logic [1:0] source_field_i,
  input  logic       dds_ready_i,
  input  logic       dds_done_i,
  input  logic       dds_active_i,
  input  logic       wfrm_ready_i,
  input  logic       wfrm_done_i,
  input  logic       wfrm_active_i,
  output logic       wfrm_selected_o,
  output logic       dds_init_o,
  output logic       dds_enable_o,
  output logic       wfrm_init_o,
  output logic       wfrm_enable_o,
  output logic       chirp_ready_o,
  output logic       chirp_done_o,
  output logic       chirp_active_o
);

  logic [1:0] source_r;
  logic       wfrm_sel;

  // source frozen for the length of a chirp
  always_ff @(posedge clk_245_76MHz) begin
    if (cpu_reset) begin
      source_r <= 2'b00;
    end else if (!chirp_enable_i) begin
      source_r <= source_field_i;
    end
  end

  // waveform generator only on code 2'b11
  assign wfrm_sel        = &source_r;
  assign wfrm_selected_o = wfrm_sel;

  ////////////////////////////////////////
  // strobe steering
  ////////////////////////////////////////

  // unselected generator sees nothing
  assign dds_init_o    = ~wfrm_sel & chirp_init_i;
  assign dds_enable_o  = ~wfrm_sel & chirp_enable_i;
  assign wfrm_init_o   =  wfrm_sel & chirp_init_i;
  assign wfrm_enable_o =  wfrm_sel & chirp_enable_i;

  // status back from whichever one is active
  assign chirp_ready_o  = wfrm_sel ? wfrm_ready_i  : dds_ready_i;
  assign chirp_done_o   = wfrm_sel ? wfrm_done_i   : dds_done_i;
  assign chirp_active_o = wfrm_sel ? wfrm_active_i : dds_active_i;

endmodule

// ==== rtl/radar_capture_pkg.sv ====
package radar_capture_pkg;

  ////////////////////////////////////////
  // data widths
  ////////////////////////////////////////

  // packed IQ sample, I in upper half
  localparam int unsigned IQ_W   = 32;
  // sample and global counters
  localparam int unsigned CNT_W  = 32;
  // one capture word
  localparam int unsigned WORD_W = 64;
  // chirp control word from the register file
  localparam int unsigned CTRL_W = 32;

  // control word field positions, 2 bits each
  localparam int unsigned ROUTE_L_LSB = 0;
  localparam int unsigned ROUTE_U_LSB = 4;
  localparam int unsigned SRC_LSB     = 8;

  ////////////////////////////////////////
  // generator latencies
  ////////////////////////////////////////

  localparam int unsigned LAT_W          = 8;
  // chirp DDS, same at start and stop
  localparam int unsigned CHIRP_DELAY    = 3;
  // waveform generator start and stop
  localparam int unsigned WFRM_DELAY     = 18;
  localparam int unsigned WFRM_DELAY_END = 2;

  // frames padded to whole blocks of this many words
  localparam int unsigned ALIGN_W     = 6;
  localparam int unsigned ALIGN_WORDS = 64;

  // per-half route codes
  localparam logic [1:0] ROUTE_ADC     = 2'd0;
  localparam logic [1:0] ROUTE_DAC     = 2'd1;
  localparam logic [1:0] ROUTE_SAMPLES = 2'd2;
  localparam logic [1:0] ROUTE_GLOBAL  = 2'd3;

  // header/trailer view and data view of the same 64-bit word
  typedef union packed {
    struct packed {
      logic [CNT_W-1:0] glbl;
      logic [CNT_W-1:0] samples;
    } hdr;
    struct packed {
      logic [WORD_W/2-1:0] upper;
      logic [WORD_W/2-1:0] lower;
    } data;
  } capture_word_t;

endpackage
